//--- idc.f
+incdir+design
design/idc_pkg.sv
design/idc_ctrl.sv
design/idc_image_buf.sv
design/idc_window_alu.sv
design/idc_zoom_out.sv
design/idc_top.sv
dv/idc_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module idc_tb -f idc.f \
	-Mdir obj_dir -o idc_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/idc_sim > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- dv/idc_tb.sv
`timescale 1ns/1ps
`include "idc_defines.svh"

module idc_tb;
	import idc_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int RST_CYCLES  = 4;
	localparam int NUM_FRAMES  = 20;
	localparam int FRAME_LIMIT = 400;  // cycles per frame, worst case is near 170
	localparam int START_IDX   = `IDC_START_POS * `IDC_IMG_DIM + `IDC_START_POS;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       in_valid;
	pixel_t     in_data;
	logic [3:0] op;
	logic       out_valid;
	pixel_t     out_data;

	integer seed = 32'h7d893bb8;
	int     mismatches;
	int     failures;  // errors that are not a wrong value
	int     bursts;    // output bursts seen so far
	int     run_len;   // length of the current out_valid run

	pixel_t     pix_q [`IDC_NUM_PIX];  // frame being sent
	logic [3:0] ops_q [`IDC_NUM_OPS];
	pixel_t     exp_q [$];             // predicted display pixels

	idc_top dut0 (
		.clk, .rst_n, .in_valid, .in_data, .op, .out_valid, .out_data
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// ====================
	// reference model
	// ====================
	function automatic int mid_of_window(input int w [4]);
		int s [4];
		int t;
		s = w;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3 - i; j++) begin
				if (s[j] > s[j+1]) begin  // plain bubble sort
					t = s[j];
					s[j] = s[j+1];
					s[j+1] = t;
				end
			end
		end
		return (s[1] + s[2]) / 2;  // int divide truncates toward zero
	endfunction

	// 7-bit two's complement, -64 has no positive twin
	function automatic int negate_pix(input int v);
		return (v == -64) ? -64 : -v;
	endfunction

	task automatic predict_frame();
		int img [`IDC_NUM_PIX];
		int w [4];
		int m;
		int x;
		int y;
		int base;
		int idx;
		x = `IDC_START_POS;
		y = `IDC_START_POS;
		for (int k = 0; k < `IDC_NUM_PIX; k++)
			img[k] = pix_q[k];  // sign extends
		for (int k = 0; k < `IDC_NUM_OPS; k++) begin
			base = y * `IDC_IMG_DIM + x;
			for (int v = 0; v < 4; v++)
				w[v] = img[base + (v / 2) * `IDC_IMG_DIM + v % 2];  // tl tr bl br
			case (ops_q[k])
				4'd0: begin
					m = mid_of_window(w);  // one value from the untouched window
					for (int v = 0; v < 4; v++) w[v] = m;
				end
				4'd1: for (int v = 0; v < 4; v++) w[v] = (img[base] + img[base+1]
					+ img[base+`IDC_IMG_DIM] + img[base+`IDC_IMG_DIM+1]) / 4;
				4'd4: for (int v = 0; v < 4; v++) w[v] = negate_pix(w[v]);
				4'd5: if (y > 0) y--;
				4'd6: if (x > 0) x--;
				4'd7: if (y < `IDC_POS_MAX) y++;
				4'd8: if (x < `IDC_POS_MAX) x++;
				default: ;  // 2, 3 do nothing
			endcase
			for (int v = 0; v < 4; v++)
				img[base + (v / 2) * `IDC_IMG_DIM + v % 2] = w[v];  // shifts write same values
		end
		for (int r = 0; r < `IDC_ZOOM_DIM; r++) begin
			for (int c = 0; c < `IDC_ZOOM_DIM; c++) begin
				if (x < `IDC_ZOOM_DIM && y < `IDC_ZOOM_DIM)
					idx = (y + 1 + r) * `IDC_IMG_DIM + x + 1 + c;  // zoom-in
				else
					idx = 2 * r * `IDC_IMG_DIM + 2 * c;  // zoom-out
				exp_q.push_back(pixel_t'(img[idx]));
			end
		end
	endtask

	// ====================
	// stimulus
	// ====================
	// kind 0 shifts, 1 flip, 2 avg, 3 mid, 4 codes 2 and 3, else anything 0..8
	task automatic pick_op(input int kind, output logic [3:0] code);
		int r;
		logic [3:0] sh;
		r = $unsigned($random(seed)) % 9;
		sh = 4'd5 + 4'(r % 4);  // up, left, down, right
		case (kind)
			0:       code = sh;
			1:       code = (r < 4) ? OP_FLIP : sh;
			2:       code = (r < 4) ? OP_AVG : sh;
			3:       code = (r < 4) ? OP_MID : sh;
			4:       code = (r < 3) ? 4'd2 : ((r < 6) ? 4'd3 : sh);
			default: code = 4'(r);
		endcase
	endtask

	task automatic send_frame(input int kind);
		for (int k = 0; k < `IDC_NUM_PIX; k++) begin
			pix_q[k] = pixel_t'($random(seed));
			if (kind == 1 && ($random(seed) & 3) == 0)
				pix_q[k] = pixel_t'(-64);  // plenty of -64 for flip
		end
		for (int k = 0; k < `IDC_NUM_OPS; k++)
			pick_op(kind, ops_q[k]);
		if (kind == 1) begin
			pix_q[START_IDX] = pixel_t'(-64);  // first flip hits it for sure
			ops_q[0] = OP_FLIP;
		end
		predict_frame();
		for (int k = 0; k < `IDC_NUM_PIX; k++) begin
			@(negedge clk);
			in_valid = 1'b1;
			in_data  = pix_q[k];
			op       = (k < `IDC_NUM_OPS) ? ops_q[k] : 4'($random(seed));  // ignored later
		end
		@(negedge clk);
		in_valid = 1'b0;
		in_data  = '0;
		op       = '0;
	endtask

	// ====================
	// output monitor
	// ====================
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				run_len++;
				if (exp_q.size() == 0) begin
					failures++;
					$display("out_valid high with no pixel expected at %0t", $time);
				end else begin
					check_value($sformatf("out_data (frame %0d pixel %0d)", bursts, run_len - 1),
						{25'd0, out_data}, {25'd0, exp_q.pop_front()});
				end
			end else if (run_len != 0) begin
				check_value("out_valid run length", run_len, `IDC_ZOOM_PIX);
				run_len = 0;
				bursts++;  // burst over, out_valid back low
			end
		end
	end

	initial begin
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_data    = '0;
		op         = '0;
		mismatches = 0;
		failures   = 0;
		bursts     = 0;
		run_len    = 0;
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		check_value("out_valid after reset", out_valid, 0);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			send_frame(f % 6);
			wait (bursts == f + 1);  // back to back, next frame once out_valid falls
		end
		@(negedge clk);
		if (exp_q.size() != 0) begin
			failures++;
			$display("%0d predicted pixels never came out", exp_q.size());
		end
		$display("closing: %0d mismatches, %0d other errors", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// watchdog
	initial begin
		#(CLK_PERIOD * (RST_CYCLES + NUM_FRAMES * FRAME_LIMIT));
		$display("timeout: only %0d of %0d frames finished", bursts, NUM_FRAMES);
		$display("closing: %0d mismatches, %0d other errors", mismatches, failures + 1);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- design/idc_top.sv
`timescale 1ns/1ps
`include "idc_defines.svh"

module idc_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  idc_pkg::pixel_t  in_data,
	input  logic [3:0]       op,
	output logic             out_valid,
	output idc_pkg::pixel_t  out_data
);
	import idc_pkg::*;

	// ====================
	// internal wires
	// ====================
	logic                            load_en;
	logic [$clog2(`IDC_NUM_PIX)-1:0] load_idx;
	pos_t                            pos;
	logic                            alu_start;
	op_e                             alu_op;
	logic                            alu_done;
	window_t                         alu_result;
	window_t                         window;
	logic                            wb_en;
	logic                            clear;
	logic                            snap;
	logic                            last;
	image_t                          image;

	// fsm, op queue, window position
	idc_ctrl u_ctrl (
		.clk, .rst_n, .in_valid, .op, .alu_done, .last,
		.load_en, .load_idx, .pos, .alu_start, .alu_op, .wb_en, .clear, .snap
	);

	// frame store, pixels go straight in from in_data
	idc_image_buf u_image_buf (
		.clk, .rst_n, .load_en, .load_idx, .in_data, .clear, .pos, .wb_en,
		.wb_window (alu_result),
		.window, .image
	);

	idc_window_alu u_window_alu (
		.clk, .rst_n, .alu_start, .alu_op, .window, .alu_done, .alu_result
	);

	// display snapshot and 16-pixel stream
	idc_zoom_out u_zoom_out (
		.clk, .rst_n, .snap, .image, .pos, .out_valid, .out_data, .last
	);

endmodule

//--- design/idc_zoom_out.sv
`timescale 1ns/1ps
`include "idc_defines.svh"

module idc_zoom_out (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             snap,
	input  idc_pkg::image_t  image,
	input  idc_pkg::pos_t    pos,
	output logic             out_valid,
	output idc_pkg::pixel_t  out_data,
	output logic             last
);
	import idc_pkg::*;

	localparam int IDX_W = $clog2(`IDC_NUM_PIX);

	pixel_t sel    [`IDC_ZOOM_PIX];
	pixel_t zoom_q [`IDC_ZOOM_PIX];  // snapshot, row order
	logic [$clog2(`IDC_ZOOM_PIX)-1:0] cnt;
	logic   zoom_in;

	// zoom-in: 4x4 block one step down-right of the corner
	// zoom-out: even rows and even columns
	function automatic logic [IDX_W-1:0] zoom_idx(pos_t p, logic zin, int r, int c);
		if (zin)
			return IDX_W'((int'(p.y) + 1 + r) * `IDC_IMG_DIM + int'(p.x) + 1 + c);
		return IDX_W'(2 * r * `IDC_IMG_DIM + 2 * c);
	endfunction

	assign zoom_in = (pos.x < coord_t'(`IDC_ZOOM_DIM)) && (pos.y < coord_t'(`IDC_ZOOM_DIM));

	always_comb begin
		for (int r = 0; r < `IDC_ZOOM_DIM; r++) begin
			for (int c = 0; c < `IDC_ZOOM_DIM; c++)
				sel[r*`IDC_ZOOM_DIM + c] = image[zoom_idx(pos, zoom_in, r, c)];
		end
	end

	always_ff @(posedge clk) begin
		if (snap)
			zoom_q <= sel;
	end

	// ====================
	// stream
	// ====================
	// pixel 0 goes out straight from sel, the rest from the snapshot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data  <= '0;
			cnt       <= '0;
		end else if (snap) begin
			out_valid <= 1'b1;
			out_data  <= sel[0];
			cnt       <= 1'b1;
		end else if (last) begin
			out_valid <= 1'b0;  // 16th pixel just went out
			out_data  <= '0;
		end else if (out_valid) begin
			out_data  <= zoom_q[cnt];
			cnt       <= cnt + 1'b1;  // wraps to 0 on pixel 15
		end
	end

	assign last = out_valid && (cnt == '0);

	a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid [*`IDC_ZOOM_PIX] |=> !out_valid);

endmodule

//--- design/idc_window_alu.sv
`timescale 1ns/1ps
`include "idc_defines.svh"

module idc_window_alu (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              alu_start,
	input  idc_pkg::op_e      alu_op,
	input  idc_pkg::window_t  window,
	output logic              alu_done,
	output idc_pkg::window_t  alu_result
);
	import idc_pkg::*;

	op_e        op_q;
	logic [1:0] cnt;   // cycles left after the start edge
	logic       done_q;
	logic       busy;

	pixel_t  p [4];  // mid: sorted pairs, then the middle two
	logic signed [`IDC_PIX_W:0]   sum_a, sum_b;  // avg pair sums
	logic signed [`IDC_PIX_W:0]   mid_sum;
	logic signed [`IDC_PIX_W+1:0] sum4;
	window_t res_q;

	function automatic pixel_t pix_max(pixel_t a, pixel_t b);
		return (a > b) ? a : b;
	endfunction

	function automatic pixel_t pix_min(pixel_t a, pixel_t b);
		return (a > b) ? b : a;
	endfunction

	// mid 3 cycles, avg 2, flip 1
	function automatic logic [1:0] op_rem(op_e o);
		case (o)
			OP_MID:  return 2'd2;
			OP_AVG:  return 2'd1;
			default: return 2'd0;
		endcase
	endfunction

	// ====================
	// control
	// ====================
	assign busy = (cnt != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_q   <= OP_MID;
			cnt    <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (alu_start) begin
				op_q   <= alu_op;
				cnt    <= op_rem(alu_op);
				done_q <= (op_rem(alu_op) == 2'd0);  // flip finishes at once
			end else if (busy) begin
				cnt    <= cnt - 1'b1;
				done_q <= (cnt == 2'd1);
			end
		end
	end

	// ====================
	// datapath
	// ====================
	assign mid_sum = p[0] + p[1];
	assign sum4    = sum_a + sum_b;

	always_ff @(posedge clk) begin
		if (alu_start) begin
			case (alu_op)
				OP_MID: begin
					p[0] <= pix_max(window.tl, window.tr);  // pair a, hi/lo
					p[1] <= pix_min(window.tl, window.tr);
					p[2] <= pix_max(window.bl, window.br);  // pair b
					p[3] <= pix_min(window.bl, window.br);
				end
				OP_AVG: begin
					sum_a <= window.tl + window.tr;
					sum_b <= window.bl + window.br;
				end
				OP_FLIP: begin
					res_q.tl <= -window.tl;  // -64 wraps back to -64
					res_q.tr <= -window.tr;
					res_q.bl <= -window.bl;
					res_q.br <= -window.br;
				end
				default: ;
			endcase
		end else if (busy) begin
			if (op_q == OP_MID && cnt == 2'd2) begin
				p[0] <= pix_min(p[0], p[2]);  // lower of the two highs
				p[1] <= pix_max(p[1], p[3]);  // upper of the two lows
			end else begin
				// last step, divide truncates toward zero
				if (op_q == OP_MID)
					res_q <= {4{pixel_t'(mid_sum / 2)}};
				else
					res_q <= {4{pixel_t'(sum4 / 4)}};
			end
		end
	end

	assign alu_done   = done_q;
	assign alu_result = res_q;

	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		alu_start |-> !busy);

endmodule

//--- design/idc_image_buf.sv
`timescale 1ns/1ps
`include "idc_defines.svh"

module idc_image_buf (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            load_en,
	input  logic [$clog2(`IDC_NUM_PIX)-1:0] load_idx,
	input  idc_pkg::pixel_t                 in_data,
	input  logic                            clear,
	input  idc_pkg::pos_t                   pos,
	input  logic                            wb_en,
	input  idc_pkg::window_t                wb_window,
	output idc_pkg::window_t                window,
	output idc_pkg::image_t                 image
);
	import idc_pkg::*;

	localparam int IDX_W = $clog2(`IDC_NUM_PIX);

	image_t img_q;  // 64 pixels, row-major

	logic [IDX_W-1:0] idx_tl;
	logic [IDX_W-1:0] idx_tr;
	logic [IDX_W-1:0] idx_bl;
	logic [IDX_W-1:0] idx_br;

	// ====================
	// window addressing
	// ====================
	// corner index is just {y, x}
	assign idx_tl = pos;
	assign idx_tr = idx_tl + 1'b1;  // x <= 6, never wraps a row
	assign idx_bl = idx_tl + IDX_W'(`IDC_IMG_DIM);  // one row down
	assign idx_br = idx_bl + 1'b1;

	// ====================
	// store
	// ====================
	// priority: clear, then load, then write-back
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			img_q <= '0;
		end else if (clear) begin
			img_q <= '0;  // no pixels carry into next frame
		end else if (load_en) begin
			img_q[load_idx] <= in_data;
		end else if (wb_en) begin
			img_q[idx_tl] <= wb_window.tl;
			img_q[idx_tr] <= wb_window.tr;
			img_q[idx_bl] <= wb_window.bl;
			img_q[idx_br] <= wb_window.br;
		end
	end

	// ====================
	// read side
	// ====================
	// window is combinational at pos
	always_comb begin
		window.tl = img_q[idx_tl];
		window.tr = img_q[idx_tr];
		window.bl = img_q[idx_bl];
		window.br = img_q[idx_br];
	end

	assign image = img_q;  // whole frame for the zoom snapshot

	// loading and op rounds are separate phases of the frame
	a_no_load_wb: assert property (@(posedge clk) disable iff (!rst_n)
		!(load_en && wb_en));

endmodule

//--- design/idc_ctrl.sv
`timescale 1ns/1ps
`include "idc_defines.svh"

module idc_ctrl (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               in_valid,
	input  logic [3:0]                         op,
	input  logic                               alu_done,
	input  logic                               last,
	output logic                               load_en,
	output logic [$clog2(`IDC_NUM_PIX)-1:0]    load_idx,
	output idc_pkg::pos_t                      pos,
	output logic                               alu_start,
	output idc_pkg::op_e                       alu_op,
	output logic                               wb_en,
	output logic                               clear,
	output logic                               snap
);
	import idc_pkg::*;

	localparam int IDX_W = $clog2(`IDC_NUM_PIX);
	localparam int RND_W = $clog2(`IDC_NUM_OPS + 1);
	localparam pos_t START_POS = '{y: coord_t'(`IDC_START_POS), x: coord_t'(`IDC_START_POS)};

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ,      // pixels streaming in
		S_DISPATCH,  // one round decoded here
		S_COMPUTE,   // waiting on the alu
		S_WRITE,     // window write-back
		S_PLACE,     // zoom snapshot
		S_DISPLAY    // 16 outputs
	} state_e;

	state_e state, state_nx;

	logic [IDX_W-1:0] load_cnt;
	logic [RND_W-1:0] round;
	logic [3:0]       op_q [`IDC_NUM_OPS];  // op queue, no reset, rewritten every frame
	logic [3:0]       cur_code;
	op_e              cur_op;
	logic             ops_done;
	logic             is_compute;

	// ====================
	// op queue
	// ====================
	assign ops_done = (round == RND_W'(`IDC_NUM_OPS));
	assign cur_code = ops_done ? 4'hf : op_q[round];  // 15 decodes as a no-op
	assign cur_op   = op_e'(cur_code);
	assign is_compute = (cur_op == OP_MID) || (cur_op == OP_AVG) || (cur_op == OP_FLIP);

	always_ff @(posedge clk) begin
		if (load_en && (load_cnt < IDX_W'(`IDC_NUM_OPS)))
			op_q[load_cnt[RND_W-1:0]] <= op;  // first 15 load cycles only
	end

	// ====================
	// fsm
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= S_IDLE;
		else
			state <= state_nx;
	end

	always_comb begin
		state_nx = state;
		case (state)
			S_IDLE:     if (in_valid) state_nx = S_READ;
			S_READ:     if (!in_valid) state_nx = S_DISPATCH;
			S_DISPATCH: begin
				if (ops_done)
					state_nx = S_PLACE;
				else if (is_compute)
					state_nx = S_COMPUTE;
				// shifts and no-ops stay, one round per cycle
			end
			S_COMPUTE:  if (alu_done) state_nx = S_WRITE;
			S_WRITE:    state_nx = S_DISPATCH;
			S_PLACE:    state_nx = S_DISPLAY;
			S_DISPLAY:  if (last) state_nx = S_IDLE;
			default:    state_nx = S_IDLE;
		endcase
	end

	// counters
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			load_cnt <= '0;
		else if (load_en)
			load_cnt <= load_cnt + 1'b1;  // wraps to 0 after pixel 63
		else if (state == S_IDLE)
			load_cnt <= '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			round <= '0;
		else if (state == S_IDLE)
			round <= '0;
		else if (state == S_WRITE)
			round <= round + 1'b1;  // compute round ends here
		else if (state == S_DISPATCH && !ops_done && !is_compute)
			round <= round + 1'b1;
	end

	// window position, saturating shifts
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos <= START_POS;
		end else if (state == S_IDLE) begin
			pos <= START_POS;
		end else if (state == S_DISPATCH && !ops_done) begin
			case (cur_op)
				OP_UP:    if (pos.y != '0) pos.y <= pos.y - 1'b1;
				OP_LEFT:  if (pos.x != '0) pos.x <= pos.x - 1'b1;
				OP_DOWN:  if (pos.y != coord_t'(`IDC_POS_MAX)) pos.y <= pos.y + 1'b1;
				OP_RIGHT: if (pos.x != coord_t'(`IDC_POS_MAX)) pos.x <= pos.x + 1'b1;
				default:  ;  // compute ops and no-ops leave pos alone
			endcase
		end
	end

	// strobes
	assign load_en   = in_valid && (state == S_IDLE || state == S_READ);
	assign load_idx  = load_cnt;
	assign alu_start = (state == S_DISPATCH) && !ops_done && is_compute;
	assign alu_op    = cur_op;
	assign wb_en     = (state == S_WRITE);
	assign snap      = (state == S_PLACE);
	assign clear     = (state == S_DISPLAY) && last;  // frame over, wipe the store

	// corner must stay inside the 7x7 range of legal window corners
	a_pos_range: assert property (@(posedge clk) disable iff (!rst_n)
		(pos.x <= coord_t'(`IDC_POS_MAX)) && (pos.y <= coord_t'(`IDC_POS_MAX)));

endmodule

//--- design/idc_pkg.sv
package idc_pkg;

`include "idc_defines.svh"

	// ====================
	// pixel and position
	// ====================
	typedef logic signed [`IDC_PIX_W-1:0] pixel_t;

	typedef logic [$clog2(`IDC_IMG_DIM)-1:0] coord_t;

	// y above x, so the struct read as a vector is the corner's pixel index
	typedef struct packed {
		coord_t y;  // row
		coord_t x;  // column
	} pos_t;

	// 2x2 window, top row first
	typedef struct packed {
		pixel_t tl;
		pixel_t tr;
		pixel_t bl;
		pixel_t br;
	} window_t;

	// whole frame, element 0 is row 0 col 0
	typedef pixel_t [`IDC_NUM_PIX-1:0] image_t;

	// ====================
	// op codes
	// ====================
	// 2, 3 and 9..15 are not listed: they just burn a round
	typedef enum logic [3:0] {
		OP_MID   = 4'd0,  // midpoint of middle two
		OP_AVG   = 4'd1,  // mean of four
		OP_FLIP  = 4'd4,  // negate
		OP_UP    = 4'd5,
		OP_LEFT  = 4'd6,
		OP_DOWN  = 4'd7,
		OP_RIGHT = 4'd8
	} op_e;

endpackage

//--- design/idc_defines.svh
`ifndef IDC_DEFINES_SVH
`define IDC_DEFINES_SVH

// ====================
// pixel and frame geometry
// ====================
`define IDC_PIX_W      7   // signed pixel width
`define IDC_IMG_DIM    8   // image is square, 8x8
`define IDC_NUM_PIX    64  // row-major, index = {row, col}

// ====================
// operation round
// ====================
`define IDC_NUM_OPS    15  // op codes captured per frame
`define IDC_POS_MAX    6   // window corner saturates here
`define IDC_START_POS  3   // corner column and row after idle

// display
`define IDC_ZOOM_DIM   4   // display side
`define IDC_ZOOM_PIX   16  // pixels streamed per frame

`endif
